//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= sifhTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/sifhChecker.sv
module sifhChecker import sifhPkg::*; (
    input  logic    clk,
    input  logic    combin_res,
    input  logic    sampleValid,
    input  logic    sampleReady,
    input  logic    resultValid,
    input  peakVecT result,
    input  logic    expValid,
    input  peakVecT expVec,
    input  int      expTest,
    output int      errCount,
    output int      resultCount
);

    // edges from the last fine sample to resultValid
    localparam int RESULT_LAT = 3;

    peakVecT expQ [$];
    int      testQ [$];
    peakVecT expNow;
    int      testNow;
    int      acceptCnt;
    // edges since the last sample of a frame, 0 when idle
    int      sinceLast;
    logic    frameFine;
    logic    fineEnded;
    logic    wantValid;

    //**************************************************
    // values seen at each edge are the ones before it
    //**************************************************

    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            expQ.delete();
            testQ.delete();
            errCount = 0;
            resultCount = 0;
            acceptCnt = 0;
            sinceLast = 0;
            frameFine = 1'b0;
            fineEnded = 1'b0;
        end else begin
            // ready gap of exactly READY_GAP cycles
            if (sinceLast >= 1 && sinceLast <= READY_GAP && sampleReady) begin
                $display("[FAIL] t=%0t sampleReady exp=0 got=1", $time);
                errCount++;
            end
            if (sinceLast == READY_GAP + 1 && !sampleReady) begin
                $display("[FAIL] t=%0t sampleReady exp=1 got=0", $time);
                errCount++;
            end
            // one pulse, three edges after the last fine sample
            wantValid = fineEnded && (sinceLast == RESULT_LAT + 1);
            if (resultValid != wantValid) begin
                $display("[FAIL] t=%0t resultValid exp=%0b got=%0b", $time, wantValid, resultValid);
                errCount++;
            end
            if (resultValid) begin
                if (expQ.size() == 0) begin
                    $display("result arrived at t=%0t with no measurement pending", $time);
                    errCount++;
                end else begin
                    expNow = expQ.pop_front();
                    testNow = testQ.pop_front();
                    resultCount++;
                    if (result != expNow) begin
                        $display("[FAIL] t=%0t result exp=%h got=%h", $time, expNow, result);
                        errCount++;
                        $display("test %0d measurement %0d: failed", testNow, resultCount);
                    end else begin
                        $display("test %0d measurement %0d: passed", testNow, resultCount);
                    end
                end
            end
            if (expValid) begin
                expQ.push_back(expVec);
                testQ.push_back(expTest);
            end
            // frame position from accepted samples
            if (sampleValid && sampleReady && acceptCnt == FRAME_LEN - 1) begin
                acceptCnt = 0;
                sinceLast = 1;
                fineEnded = frameFine;
                frameFine = !frameFine;
            end else begin
                if (sampleValid && sampleReady) begin
                    acceptCnt++;
                end
                if (sinceLast == READY_GAP + 1) begin
                    sinceLast = 0;
                end else if (sinceLast != 0) begin
                    sinceLast++;
                end
            end
        end
    end

endmodule

//--- dv/sifhTb.sv
module sifhTb import sifhPkg::*; ();

    localparam logic [31:0] SEED = 32'he974a0e7;
    // measurements per directed test
    localparam int MEAS_PER_TEST = 3;
    // cycles any single wait may take
    localparam int TIMEOUT = 200;

    logic    clk;
    logic    combin_res;
    logic    sampleValid;
    logic    sampleReady;
    sampleT  sample;
    logic    resultValid;
    peakVecT result;

    // expected values handed to the checker
    logic    expValid;
    peakVecT expVec;
    int      expTest;
    int      errCount;
    int      resultCount;
    int      pushCount;
    int      waitCnt;
    // set once a wait runs out
    logic    timedOut;

    sifhTop u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .sample      (sample),
        .resultValid (resultValid),
        .result      (result)
    );

    sifhChecker u_check (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .resultValid (resultValid),
        .result      (result),
        .expValid    (expValid),
        .expVec      (expVec),
        .expTest     (expTest),
        .errCount    (errCount),
        .resultCount (resultCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //**************************************************
    // frame order and reference model
    //**************************************************

    // acquisition-major order with DATA_NUM samples per visit
    function automatic int pixelOf(input int i);
        return (i / DATA_NUM) % PIXEL_NUM;
    endfunction

    // index of a sample among the 8 its pixel gets per frame
    function automatic int slotOf(input int i);
        return (i / (PIXEL_NUM * DATA_NUM)) * DATA_NUM + i % DATA_NUM;
    endfunction

    function automatic peakVecT sifhModel(input sampleT cf [FRAME_LEN],
                                          input sampleT ff [FRAME_LEN]);
        int      cnt [PIXEL_NUM][16];
        int      best [PIXEL_NUM];
        int      peak [PIXEL_NUM];
        int      lower [PIXEL_NUM];
        int      p;
        int      s;
        int      b;
        int      ch;
        peakVecT res;
        for (int frame = 0; frame < 2; frame++) begin
            for (int q = 0; q < PIXEL_NUM; q++) begin
                best[q] = 0;
                peak[q] = 0;
                for (int j = 0; j < 16; j++) begin
                    cnt[q][j] = 0;
                end
            end
            for (int i = 0; i < FRAME_LEN; i++) begin
                p = pixelOf(i);
                s = (frame == 0) ? int'(cf[i]) : int'(ff[i]);
                // 255 is no event
                // fine frame keeps a 16 wide window only
                if (s == 255) begin
                    b = -1;
                end else if (frame == 0) begin
                    b = s / 16;
                end else if (s >= lower[p] && s < lower[p] + 16) begin
                    b = s - lower[p];
                end else begin
                    b = -1;
                end
                // strictly greater so the first bin to a level wins
                if (b >= 0) begin
                    cnt[p][b]++;
                    if (cnt[p][b] > best[p]) begin
                        best[p] = cnt[p][b];
                        peak[p] = b;
                    end
                end
            end
            if (frame == 0) begin
                for (int q = 0; q < PIXEL_NUM; q++) begin
                    ch = peak[q] * 16;
                    lower[q] = (ch > 238) ? 238 : ((ch <= 8) ? 0 : ch - 8);
                end
            end
        end
        for (int q = 0; q < PIXEL_NUM; q++) begin
            res[q] = sampleT'(lower[q] + peak[q]);
        end
        return res;
    endfunction

    //**************************************************
    // stimulus
    //**************************************************

    function automatic sampleT makeSample(input int kind, input int p, input int k,
                                          input bit fine, input int centre);
        int noise;
        noise = int'($urandom_range(4)) - 2;
        case (kind)
            3: begin
                // pixel 0 always empty and pixel 1 empty in the fine frame
                if (p == 0 || (p == 1 && fine && k % 2 == 0) || (p == 2 && k % 3 == 0)) begin
                    return 8'hFF;
                end else if (p == 1 && fine) begin
                    // far outside the window
                    return sampleT'(centre + 128);
                end else if (p == 3 && fine && k < 3) begin
                    return sampleT'(centre - 40);
                end
                return sampleT'(centre + noise);
            end
            4: begin
                // two values alternate and odd pixels start with the second
                if ((k % 2) == (p % 2)) begin
                    return sampleT'((p < 2) ? 50 : 70);
                end
                return sampleT'((p < 2) ? 54 : 90);
            end
            5: begin
                if ($urandom_range(7) == 0) begin
                    return 8'hFF;
                end
                return sampleT'(centre + int'($urandom_range(12)) - 6);
            end
            default: return sampleT'(centre + noise);
        endcase
    endfunction

    // entered and left on a falling edge
    task automatic sendSample(input sampleT s);
        int cnt;
        cnt = 0;
        while (!sampleReady && cnt < TIMEOUT) begin
            sampleValid = 1'b0;
            @(negedge clk);
            cnt++;
        end
        if (!sampleReady) begin
            sampleValid = 1'b0;
            $display("timeout: sampleReady stayed low, input stream is stuck");
            timedOut = 1'b1;
        end else begin
            sampleValid = 1'b1;
            sample = s;
            @(negedge clk);
        end
    endtask

    task automatic sendFrame(input sampleT f [FRAME_LEN], input int gapMax);
        int n;
        for (int i = 0; i < FRAME_LEN && !timedOut; i++) begin
            n = (gapMax > 0) ? int'($urandom_range(gapMax)) : 0;
            if (n > 0) begin
                sampleValid = 1'b0;
                repeat (n) @(negedge clk);
            end
            sendSample(f[i]);
        end
        sampleValid = 1'b0;
    endtask

    // coarse and fine frame of one measurement
    task automatic runMeasurement(input int kind, input int gapMax);
        sampleT cf [FRAME_LEN];
        sampleT ff [FRAME_LEN];
        int     centre [PIXEL_NUM];
        int     p;
        for (int q = 0; q < PIXEL_NUM; q++) begin
            case (kind)
                // top clamp, bottom, just above zero, top clamp again
                2: centre[q] = (q == 0) ? 250 : ((q == 1) ? 3 : ((q == 2) ? 18 : 240));
                3: centre[q] = 50 * (q + 1);
                default: centre[q] = int'($urandom_range(230, 20));
            endcase
        end
        for (int i = 0; i < FRAME_LEN; i++) begin
            p = pixelOf(i);
            cf[i] = makeSample(kind, p, slotOf(i), 1'b0, centre[p]);
            ff[i] = makeSample(kind, p, slotOf(i), 1'b1, centre[p]);
        end
        expVec = sifhModel(cf, ff);
        expTest = kind;
        expValid = 1'b1;
        @(negedge clk);
        expValid = 1'b0;
        pushCount++;
        sendFrame(cf, gapMax);
        sendFrame(ff, gapMax);
    endtask

    //**************************************************
    // test sequence
    //**************************************************

    initial begin
        void'($urandom(SEED));
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        expValid = 1'b0;
        expVec = '0;
        expTest = 0;
        pushCount = 0;
        timedOut = 1'b0;
        repeat (2) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        // tests 1 to 4 stream without gaps
        for (int t = 1; t <= 4 && !timedOut; t++) begin
            for (int m = 0; m < MEAS_PER_TEST && !timedOut; m++) begin
                runMeasurement(t, 0);
            end
        end
        // random gaps and back-to-back measurements
        for (int m = 0; m < 2 * MEAS_PER_TEST && !timedOut; m++) begin
            runMeasurement(5, 3);
        end
        waitCnt = 0;
        while (!timedOut && resultCount < pushCount && waitCnt < TIMEOUT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!timedOut && resultCount < pushCount) begin
            $display("timeout: resultValid never came for the last measurement");
            timedOut = 1'b1;
        end
        // room for the final gap check
        repeat (READY_GAP + 2) @(negedge clk);
        $display("results checked: %0d of %0d, errors: %0d", resultCount, pushCount, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sources.f
src/sifhPkg.sv
src/sampleFilter.sv
src/histogramBuilder.sv
src/peakTracker.sv
src/windowCalc.sv
src/sifhTop.sv
dv/sifhChecker.sv
dv/sifhTb.sv

//--- src/histogramBuilder.sv
module histogramBuilder import sifhPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  filtBeatT filtBeat,
    output histBeatT histBeat
);

    // one histogram of 16 bins per pixel
    countT binCnt [PIXEL_NUM][2 ** NB];
    // bin holds a count of this frame
    logic [PIXEL_NUM-1:0][(2 ** NB)-1:0] written;

    countT curCnt;
    logic  curWritten;
    countT newCnt;

    //**************************************************
    // read side
    //**************************************************

    assign curCnt = binCnt[filtBeat.pixel][filtBeat.bin];
    assign curWritten = written[filtBeat.pixel][filtBeat.bin];

    // an unwritten bin counts as empty
    assign newCnt = curWritten ? curCnt + 1'b1 : countT'(1);

    //**************************************************
    // write side
    //**************************************************

    // counter storage
    always_ff @(posedge clk) begin
        if (filtBeat.valid) begin
            binCnt[filtBeat.pixel][filtBeat.bin] <= newCnt;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            written <= '0;
        end else if (filtBeat.lastOfFrame) begin
            // whole array cleared at once after the final update
            written <= '0;
        end else if (filtBeat.valid) begin
            written[filtBeat.pixel][filtBeat.bin] <= 1'b1;
        end
    end

    // beat to the peak tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            histBeat <= '0;
        end else begin
            histBeat.valid <= filtBeat.valid;
            histBeat.pass <= filtBeat.pass;
            histBeat.pixel <= filtBeat.pixel;
            histBeat.bin <= filtBeat.bin;
            histBeat.count <= newCnt;
            histBeat.lastOfFrame <= filtBeat.lastOfFrame;
        end
    end

    // a wrapped counter would show up as zero one cycle later
    assert property (@(posedge clk) disable iff (!combin_res)
        filtBeat.valid |=> (histBeat.count != '0));

endmodule

//--- src/peakTracker.sv
module peakTracker import sifhPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  histBeatT histBeat,
    output binVecT   peakBins,
    output logic     peakDone,
    output passE     donePass
);

    // running maximum per pixel
    countT [PIXEL_NUM-1:0] maxCnt;
    // bin that first reached it
    binVecT binReg;

    countT [PIXEL_NUM-1:0] nextMax;
    binVecT                nextBin;

    //**************************************************
    // compare
    //**************************************************

    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            // strictly greater, ties keep the earlier bin
            if (histBeat.valid && (histBeat.pixel == pixelT'(p)) &&
                (histBeat.count > maxCnt[p])) begin
                nextMax[p] = histBeat.count;
                nextBin[p] = histBeat.bin;
            end else begin
                nextMax[p] = maxCnt[p];
                nextBin[p] = binReg[p];
            end
        end
    end

    //**************************************************
    // track and publish
    //**************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCnt <= '0;
            binReg <= '0;
            peakDone <= 1'b0;
            donePass <= PASS_COARSE;
        end else begin
            peakDone <= histBeat.lastOfFrame;
            if (histBeat.lastOfFrame) begin
                donePass <= histBeat.pass;
                // empty pixels come out as bin 0
                maxCnt <= '0;
                binReg <= '0;
            end else begin
                maxCnt <= nextMax;
                binReg <= nextBin;
            end
        end
    end

    // last beat's update is included
    always_ff @(posedge clk) begin
        if (histBeat.lastOfFrame) begin
            peakBins <= nextBin;
        end
    end

endmodule

//--- src/sampleFilter.sv
module sampleFilter import sifhPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  logic     sampleValid,
    input  sampleT   sample,
    output logic     sampleReady,
    input  peakVecT  lowerEdge,
    output filtBeatT filtBeat
);

    localparam int VISIT_W = $clog2(DATA_NUM);
    localparam int ACQ_W = $clog2(ACQ_NUM);
    localparam int GAP_W = $clog2(READY_GAP);

    logic [VISIT_W-1:0] visitCnt;
    pixelT              pixelCnt;
    logic [ACQ_W-1:0]   acqCnt;
    logic [GAP_W-1:0]   gapCnt;
    passE               pass;

    logic   accept;
    logic   lastSample;
    logic   noEvent;
    logic   inWin;
    sampleT winLow;
    sampleT offset;
    binT    binNext;

    assign accept = sampleValid && sampleReady;
    // last visit of the last pixel in the last acquisition
    assign lastSample = (acqCnt == ACQ_W'(ACQ_NUM - 1)) &&
                        (pixelCnt == pixelT'(PIXEL_NUM - 1)) &&
                        (visitCnt == VISIT_W'(DATA_NUM - 1));

    //**************************************************
    // binning
    //**************************************************

    // all ones marks a pixel without event
    assign noEvent = (sample == '1);
    assign winLow = lowerEdge[pixelCnt];
    assign offset = sample - winLow;
    // window [winLow, winLow + 16) compared in 9 bits
    assign inWin = (sample >= winLow) &&
                   ({1'b0, sample} < ({1'b0, winLow} + 9'(2 ** NB)));

    always_comb begin
        if (pass == PASS_COARSE) begin
            // top bits only
            binNext = sample[NP-1 -: NB];
        end else begin
            binNext = offset[NB-1:0];
        end
    end

    //**************************************************
    // frame position and ready gap
    //**************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            visitCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            gapCnt <= '0;
            pass <= PASS_COARSE;
            sampleReady <= 1'b1;
            filtBeat <= '0;
        end else begin
            filtBeat.valid <= accept && !noEvent && ((pass == PASS_COARSE) || inWin);
            filtBeat.pass <= pass;
            filtBeat.pixel <= pixelCnt;
            filtBeat.bin <= binNext;
            // frame end travels even when the sample is dropped
            filtBeat.lastOfFrame <= accept && lastSample;
            if (accept) begin
                if (visitCnt == VISIT_W'(DATA_NUM - 1)) begin
                    visitCnt <= '0;
                    if (pixelCnt == pixelT'(PIXEL_NUM - 1)) begin
                        pixelCnt <= '0;
                        acqCnt <= (acqCnt == ACQ_W'(ACQ_NUM - 1)) ? '0 : acqCnt + 1'b1;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    visitCnt <= visitCnt + 1'b1;
                end
                if (lastSample) begin
                    // swap pass and hold off the source
                    pass <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                    sampleReady <= 1'b0;
                    gapCnt <= GAP_W'(READY_GAP - 1);
                end
            end else if (!sampleReady) begin
                if (gapCnt == '0) begin
                    sampleReady <= 1'b1;
                end else begin
                    gapCnt <= gapCnt - 1'b1;
                end
            end
        end
    end

    // fine beat maps back into the window it was taken from
    assert property (@(posedge clk) disable iff (!combin_res)
        filtBeat.valid && (filtBeat.pass == PASS_FINE) |-> $stable(lowerEdge) &&
            (({1'b0, lowerEdge[filtBeat.pixel]} + 9'(filtBeat.bin)) < 9'(2 ** NP - 1)));

endmodule

//--- src/sifhPkg.sv
package sifhPkg;

    //**************************************************
    // sizes of the sensor array and the frame
    //**************************************************

    // sample width
    localparam int NP = 8;
    // bin index width, 16 bins per histogram
    localparam int NB = 4;
    localparam int PIXEL_NUM = 4;
    // consecutive samples per pixel visit
    localparam int DATA_NUM = 2;
    // visits per pixel per frame
    localparam int ACQ_NUM = 4;
    localparam int FRAME_LEN = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    // 8 samples per pixel and frame fit in 4 bits
    localparam int COUNT_W = 4;

    //**************************************************
    // window and gap constants
    //**************************************************

    // half of the fine window
    localparam int HALF_WIN = 2 ** (NB - 1);
    // highest lower edge, keeps edge + 16 below the marker
    localparam int WIN_TOP = (2 ** NP - 1) - 2 * HALF_WIN - 1;
    // idle cycles after the last sample of a frame
    localparam int READY_GAP = 4;

    //**************************************************
    // types
    //**************************************************

    typedef enum logic {
        PASS_COARSE,
        PASS_FINE
    } passE;

    typedef logic [NP-1:0] sampleT;
    typedef logic [NB-1:0] binT;
    typedef logic [1:0] pixelT;
    typedef logic [COUNT_W-1:0] countT;

    // stage 1 to stage 2
    typedef struct packed {
        logic  valid;
        passE  pass;
        pixelT pixel;
        binT   bin;
        logic  lastOfFrame;
    } filtBeatT;

    // stage 2 to stage 3, count is the value after the update
    typedef struct packed {
        logic  valid;
        passE  pass;
        pixelT pixel;
        binT   bin;
        countT count;
        logic  lastOfFrame;
    } histBeatT;

    typedef sampleT [PIXEL_NUM-1:0] peakVecT;
    typedef binT [PIXEL_NUM-1:0] binVecT;

endpackage

//--- src/sifhTop.sv
module sifhTop import sifhPkg::*; (
    input  logic    clk,
    input  logic    combin_res,
    input  logic    sampleValid,
    output logic    sampleReady,
    input  sampleT  sample,
    output logic    resultValid,
    output peakVecT result
);

    //**************************************************
    // stage links
    //**************************************************

    filtBeatT filtBeat;
    histBeatT histBeat;
    binVecT   peakBins;
    logic     peakDone;
    passE     donePass;
    // window feedback from stage 4
    peakVecT  lowerEdge;

    // stage 1, framing and binning
    sampleFilter u_filter (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .sampleReady (sampleReady),
        .lowerEdge   (lowerEdge),
        .filtBeat    (filtBeat)
    );

    // stage 2, bin counts
    histogramBuilder u_hist (
        .clk        (clk),
        .combin_res (combin_res),
        .filtBeat   (filtBeat),
        .histBeat   (histBeat)
    );

    // stage 3, peak per pixel
    peakTracker u_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .histBeat   (histBeat),
        .peakBins   (peakBins),
        .peakDone   (peakDone),
        .donePass   (donePass)
    );

    // stage 4, windows and results
    windowCalc u_window (
        .clk         (clk),
        .combin_res  (combin_res),
        .peakBins    (peakBins),
        .peakDone    (peakDone),
        .donePass    (donePass),
        .lowerEdge   (lowerEdge),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

//--- src/windowCalc.sv
module windowCalc import sifhPkg::*; (
    input  logic    clk,
    input  logic    combin_res,
    input  binVecT  peakBins,
    input  logic    peakDone,
    input  passE    donePass,
    output peakVecT lowerEdge,
    output logic    resultValid,
    output peakVecT result
);

    //**************************************************
    // window rule
    //**************************************************

    // lower edge from a coarse bin
    function automatic sampleT winEdge(input binT coarse);
        sampleT ch;
        // start of the coarse bin in sample units
        ch = {coarse, {(NP - NB){1'b0}}};
        if (ch > sampleT'(WIN_TOP)) begin
            return sampleT'(WIN_TOP);
        end else if (ch <= sampleT'(HALF_WIN)) begin
            return '0;
        end else begin
            return ch - sampleT'(HALF_WIN);
        end
    endfunction

    //**************************************************
    // edges and results
    //**************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            lowerEdge <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= peakDone && (donePass == PASS_FINE);
            if (peakDone && (donePass == PASS_COARSE)) begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    lowerEdge[p] <= winEdge(peakBins[p]);
                end
            end
        end
    end

    // result held until the next fine frame ends
    always_ff @(posedge clk) begin
        if (peakDone && (donePass == PASS_FINE)) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                // peak bin is an offset from the edge
                result[p] <= lowerEdge[p] + sampleT'(peakBins[p]);
            end
        end
    end

    // a frame end arrives as a single pulse
    assert property (@(posedge clk) disable iff (!combin_res)
        peakDone |=> !peakDone);

endmodule
